/* source/fpmul_pkg.sv */
package fpmul_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Field widths and bias
	////////////////////////////////////////////////////////////////////////////

	localparam int EXP_W    = 8;     // Biased exponent
	localparam int FRAC_W   = 23;    // Stored fraction, hidden one not included
	localparam int EXP_BIAS = 127;

	// Exception flag word, no divide-by-zero bit for a multiply
	localparam int FLAG_W         = 4;
	localparam int FLAG_INVALID   = 3;
	localparam int FLAG_OVERFLOW  = 2;
	localparam int FLAG_UNDERFLOW = 1;
	localparam int FLAG_INEXACT   = 0;

	// Operand class codes
	localparam logic [1:0] CLS_ZERO = 2'd0;    // Also flushed subnormals
	localparam logic [1:0] CLS_NORM = 2'd1;
	localparam logic [1:0] CLS_INF  = 2'd2;
	localparam logic [1:0] CLS_NAN  = 2'd3;

	localparam logic [31:0] QNAN = 32'h7fc0_0000;    // Canonical quiet NaN

	////////////////////////////////////////////////////////////////////////////
	// Single-precision word, raw or split into fields
	////////////////////////////////////////////////////////////////////////////

	typedef union packed {
		logic [31:0] bits;
		struct packed {
			logic              sign;
			logic [EXP_W-1:0]  exp;
			logic [FRAC_W-1:0] frac;
		} fields;
	} fp32_u;

endpackage

/* source/fpmul_decode.sv */
module fpmul_decode import fpmul_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	input  logic             in_valid,
	input  fp32_u            a,
	input  fp32_u            b,
	output logic             dec_valid,
	output logic             sign_a,
	output logic             sign_b,
	output logic [EXP_W-1:0] exp_a,
	output logic [EXP_W-1:0] exp_b,
	output logic [FRAC_W:0]  sig_a,     // Hidden one inserted
	output logic [FRAC_W:0]  sig_b,
	output logic [1:0]       cls_a,
	output logic [1:0]       cls_b,
	output logic             dec_invalid
);

	// Zero exponent covers subnormals as well, so they flush to signed zero
	function automatic logic [1:0] classify(input fp32_u x);
		if (x.fields.exp == '0)
			return CLS_ZERO;
		if (x.fields.exp == '1)
			return (x.fields.frac == '0) ? CLS_INF : CLS_NAN;
		return CLS_NORM;
	endfunction

	// Signalling NaN has the quiet bit clear
	function automatic logic is_snan(input fp32_u x);
		return (x.fields.exp == '1) && (x.fields.frac != '0) && !x.fields.frac[FRAC_W-1];
	endfunction

	logic [1:0] cls_a_c;
	logic [1:0] cls_b_c;
	logic       invalid_c;

	assign cls_a_c = classify(a);
	assign cls_b_c = classify(b);

	// sNaN on either side, or inf times zero in either order
	assign invalid_c = is_snan(a) || is_snan(b) ||
		(cls_a_c == CLS_INF && cls_b_c == CLS_ZERO) ||
		(cls_a_c == CLS_ZERO && cls_b_c == CLS_INF);

	always_ff @(posedge clk) begin
		if (rst)
			dec_valid <= 1'b0;
		else
			dec_valid <= in_valid;
	end

	// Operand payload, loaded only on an accepted op
	always_ff @(posedge clk) begin
		if (in_valid) begin
			sign_a      <= a.fields.sign;
			sign_b      <= b.fields.sign;
			exp_a       <= a.fields.exp;
			exp_b       <= b.fields.exp;
			sig_a       <= (cls_a_c == CLS_NORM) ? {1'b1, a.fields.frac} : '0;
			sig_b       <= (cls_b_c == CLS_NORM) ? {1'b1, b.fields.frac} : '0;
			cls_a       <= cls_a_c;
			cls_b       <= cls_b_c;
			dec_invalid <= invalid_c;
		end
	end

	// Upstream must present clean operands with every issue
	a_operands_known: assert property (@(posedge clk) disable iff (rst)
		in_valid |-> !$isunknown({a.bits, b.bits}));

endmodule

/* source/fpmul_execute.sv */
module fpmul_execute import fpmul_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   dec_valid,
	input  logic                   sign_a,
	input  logic                   sign_b,
	input  logic [EXP_W-1:0]       exp_a,
	input  logic [EXP_W-1:0]       exp_b,
	input  logic [FRAC_W:0]        sig_a,
	input  logic [FRAC_W:0]        sig_b,
	input  logic [1:0]             cls_a,
	input  logic [1:0]             cls_b,
	input  logic                   dec_invalid,
	output logic                   ex_valid,
	output logic [2*FRAC_W+1:0]    prod,       // 48-bit significand product
	output logic signed [9:0]      exp_sum,    // Biased product exponent
	output logic                   sign_p,
	output logic [1:0]             cls_p,
	output logic                   ex_invalid
);

	logic signed [9:0] exp_sum_c;
	logic [1:0]        cls_c;

	// Ea + Eb - bias needs 10 signed bits for -125 to 381
	assign exp_sum_c = signed'({2'b00, exp_a}) + signed'({2'b00, exp_b}) - 10'(EXP_BIAS);

	// NaN wins over inf over zero
	always_comb begin
		if (cls_a == CLS_NAN || cls_b == CLS_NAN || dec_invalid)
			cls_c = CLS_NAN;    // inf * 0 lands here too
		else if (cls_a == CLS_INF || cls_b == CLS_INF)
			cls_c = CLS_INF;
		else if (cls_a == CLS_ZERO || cls_b == CLS_ZERO)
			cls_c = CLS_ZERO;
		else
			cls_c = CLS_NORM;
	end

	always_ff @(posedge clk) begin
		if (rst)
			ex_valid <= 1'b0;
		else
			ex_valid <= dec_valid;
	end

	always_ff @(posedge clk) begin
		if (dec_valid) begin
			prod       <= sig_a * sig_b;    // 24 x 24 unsigned
			exp_sum    <= exp_sum_c;
			sign_p     <= sign_a ^ sign_b;
			cls_p      <= cls_c;
			ex_invalid <= dec_invalid;
		end
	end

	// Leading one in bit 47 or 46 for the one-place normalize in result
	a_norm_product: assert property (@(posedge clk) disable iff (rst)
		ex_valid && cls_p == CLS_NORM |-> prod[2*FRAC_W+1] || prod[2*FRAC_W]);

endmodule

/* source/fpmul_result.sv */
module fpmul_result import fpmul_pkg::*; (
	input  logic                clk,
	input  logic                rst,
	input  logic                ex_valid,
	input  logic [47:0]         prod,
	input  logic signed [9:0]   exp_sum,
	input  logic                sign_p,
	input  logic [1:0]          cls_p,
	input  logic                ex_invalid,
	output logic                push,
	output fp32_u               z,
	output logic [FLAG_W-1:0]   flags
);

	logic [FRAC_W-1:0] mant;       // Normalized fraction before rounding
	logic              g;          // Guard
	logic              r;          // Round
	logic              s;          // Sticky
	logic              rnd_up;
	logic [FRAC_W:0]   mant_r;     // Carry out on top
	logic signed [9:0] exp_n;
	logic signed [9:0] exp_r;
	logic              inexact;
	fp32_u             z_c;
	logic [FLAG_W-1:0] flags_c;

	////////////////////////////////////////////////////////////////////////////
	// Normalize and round to nearest even
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Product of two 1.x values is 1.x or 1x.x
		if (prod[47]) begin
			mant = prod[46:24];
			g    = prod[23];
			r    = prod[22];
			s    = |prod[21:0];
		end else begin
			mant = prod[45:23];
			g    = prod[22];
			r    = prod[21];
			s    = |prod[20:0];
		end
		exp_n = exp_sum + $signed({9'd0, prod[47]});

		// Up when past half, or exactly half with odd lsb
		rnd_up  = g & (r | s | mant[0]);
		mant_r  = {1'b0, mant} + {{FRAC_W{1'b0}}, rnd_up};
		// 1.111..1 rounding up leaves frac zero, only the exponent moves
		exp_r   = exp_n + $signed({9'd0, mant_r[FRAC_W]});
		inexact = g | r | s;
	end

	////////////////////////////////////////////////////////////////////////////
	// Pack by class and exponent range
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		z_c.bits        = '0;
		flags_c         = '0;
		z_c.fields.sign = sign_p;
		case (cls_p)
			CLS_NAN: begin
				z_c.bits              = QNAN;          // Sign dropped too
				flags_c[FLAG_INVALID] = ex_invalid;    // Quiet NaN in, no flag
			end
			CLS_INF:  z_c.fields.exp = '1;              // Signed infinity, exact
			CLS_ZERO: z_c.fields.exp = '0;              // Signed zero, exact
			default: begin
				if (exp_r > 10'(2 * EXP_BIAS)) begin
					// Beyond largest finite
					z_c.fields.exp          = '1;
					flags_c[FLAG_OVERFLOW]  = 1'b1;
					flags_c[FLAG_INEXACT]   = 1'b1;
				end else if (exp_r < 10'sd1) begin
					// No subnormal outputs, nonzero value lost entirely
					flags_c[FLAG_UNDERFLOW] = 1'b1;
					flags_c[FLAG_INEXACT]   = 1'b1;
				end else begin
					z_c.fields.exp        = exp_r[EXP_W-1:0];
					z_c.fields.frac       = mant_r[FRAC_W-1:0];
					flags_c[FLAG_INEXACT] = inexact;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			push <= 1'b0;
		else
			push <= ex_valid;
	end

	always_ff @(posedge clk) begin
		if (ex_valid) begin
			z.bits <= z_c.bits;    // Leaves as a raw word
			flags  <= flags_c;
		end
	end

endmodule

/* source/fpmul_credit_queue.sv */
module fpmul_credit_queue import fpmul_pkg::*; #(
	parameter int FIFO_DEPTH  = 8,
	parameter int OUT_CREDITS = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              push,
	input  fp32_u             z_in,
	input  logic [FLAG_W-1:0] flags_in,
	input  logic              out_credit,    // One credit back from consumer
	output logic              out_valid,
	output logic [31:0]       z,
	output logic [FLAG_W-1:0] flags,
	output logic              in_credit      // One slot freed for upstream
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	localparam int CRD_W = $clog2(OUT_CREDITS + 1);

	logic [31:0]       mem_z [FIFO_DEPTH];
	logic [FLAG_W-1:0] mem_f [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic [CRD_W-1:0]  credits;    // Downstream credits held
	logic              pop;

	// Head leaves only when the consumer has room for it
	assign pop = (count != '0) && (credits != '0);

	////////////////////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (push) begin
			mem_z[wr_ptr] <= z_in.bits;
			mem_f[wr_ptr] <= flags_in;
		end
		if (pop) begin
			z     <= mem_z[rd_ptr];    // Held until next pop
			flags <= mem_f[rd_ptr];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Pointers, count and credits
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			credits   <= CRD_W'(OUT_CREDITS);
			out_valid <= 1'b0;
			in_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count     <= count + CNT_W'(push) - CNT_W'(pop);
			credits   <= credits - CRD_W'(pop) + CRD_W'(out_credit);    // Both may hit
			out_valid <= pop;
			in_credit <= pop;
		end
	end

	// Upstream credit accounting keeps a slot for every issued op
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		push |-> count != CNT_W'(FIFO_DEPTH));

	// Consumer never returns more than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits <= CRD_W'(OUT_CREDITS));

endmodule

/* source/fpmul_top.sv */
module fpmul_top import fpmul_pkg::*; #(
	parameter int FIFO_DEPTH  = 8,
	parameter int OUT_CREDITS = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_valid,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	input  logic              out_credit,
	output logic              in_credit,
	output logic              out_valid,
	output logic [31:0]       z,
	output logic [FLAG_W-1:0] flags
);

	// Decode to execute
	logic              dec_valid;
	logic              sign_a;
	logic              sign_b;
	logic [EXP_W-1:0]  exp_a;
	logic [EXP_W-1:0]  exp_b;
	logic [FRAC_W:0]   sig_a;
	logic [FRAC_W:0]   sig_b;
	logic [1:0]        cls_a;
	logic [1:0]        cls_b;
	logic              dec_invalid;

	// Execute to result
	logic              ex_valid;
	logic [47:0]       prod;
	logic signed [9:0] exp_sum;
	logic              sign_p;
	logic [1:0]        cls_p;
	logic              ex_invalid;

	// Result to queue
	logic              push;
	fp32_u             z_res;
	logic [FLAG_W-1:0] flags_res;

	fpmul_decode fpmul_decode_i (
		.clk         (clk),
		.rst         (rst),
		.in_valid    (in_valid),
		.a           (a),
		.b           (b),
		.dec_valid   (dec_valid),
		.sign_a      (sign_a),
		.sign_b      (sign_b),
		.exp_a       (exp_a),
		.exp_b       (exp_b),
		.sig_a       (sig_a),
		.sig_b       (sig_b),
		.cls_a       (cls_a),
		.cls_b       (cls_b),
		.dec_invalid (dec_invalid)
	);

	fpmul_execute fpmul_execute_i (
		.clk         (clk),
		.rst         (rst),
		.dec_valid   (dec_valid),
		.sign_a      (sign_a),
		.sign_b      (sign_b),
		.exp_a       (exp_a),
		.exp_b       (exp_b),
		.sig_a       (sig_a),
		.sig_b       (sig_b),
		.cls_a       (cls_a),
		.cls_b       (cls_b),
		.dec_invalid (dec_invalid),
		.ex_valid    (ex_valid),
		.prod        (prod),
		.exp_sum     (exp_sum),
		.sign_p      (sign_p),
		.cls_p       (cls_p),
		.ex_invalid  (ex_invalid)
	);

	fpmul_result fpmul_result_i (
		.clk        (clk),
		.rst        (rst),
		.ex_valid   (ex_valid),
		.prod       (prod),
		.exp_sum    (exp_sum),
		.sign_p     (sign_p),
		.cls_p      (cls_p),
		.ex_invalid (ex_invalid),
		.push       (push),
		.z          (z_res),
		.flags      (flags_res)
	);

	fpmul_credit_queue #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) fpmul_credit_queue_i (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.z_in       (z_res),
		.flags_in   (flags_res),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.z          (z),
		.flags      (flags),
		.in_credit  (in_credit)
	);

endmodule

/* tb/fpmul_tb.sv */
module fpmul_tb import fpmul_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_ROWS     = 23;
	localparam int FIFO_SLOTS = 8;    // Upstream credits after reset
	localparam int OUT_SLOTS  = 4;    // Downstream credits after reset

	typedef struct {
		string             name;
		logic [31:0]       a;
		logic [31:0]       b;
		logic [31:0]       z;
		logic [FLAG_W-1:0] flags;    // invalid, overflow, underflow, inexact
	} row_t;

	logic              clk;
	logic              rst;
	logic              in_valid;
	fp32_u             a_in;
	fp32_u             b_in;
	logic              out_credit;
	logic              in_credit;
	logic              out_valid;
	logic [31:0]       z;
	logic [FLAG_W-1:0] flags;

	row_t        rows [N_ROWS];
	logic [31:0] lfsr_state = 32'hb2b4_dfdd;

	fpmul_top #(
		.FIFO_DEPTH  (FIFO_SLOTS),
		.OUT_CREDITS (OUT_SLOTS)
	) fpmul_top_i (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.a          (a_in.bits),
		.b          (b_in.bits),
		.out_credit (out_credit),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.z          (z),
		.flags      (flags)
	);

	// Taps 32, 22, 2, 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	task automatic compare_word(input string name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s: %s expected %0h, actual %0h", name, what, expected, actual);
			$display("Test FAILED");
			$fatal(1, "wrong %s", what);
		end
	endtask

	task automatic report_flow_error(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "flow control broken");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Operands and expected results, in issue order
	////////////////////////////////////////////////////////////////////////////

	task automatic load_table();
		// Exact products
		rows[0]  = '{"exact_1p5_x_2",     32'h3fc0_0000, 32'h4000_0000, 32'h4040_0000, 4'b0000};
		rows[1]  = '{"exact_n3_x_half",   32'hc040_0000, 32'h3f00_0000, 32'hbfc0_0000, 4'b0000};
		rows[2]  = '{"exact_one",         32'h3f80_0000, 32'h3f80_0000, 32'h3f80_0000, 4'b0000};
		rows[3]  = '{"max_finite_x_one",  32'h7f7f_ffff, 32'h3f80_0000, 32'h7f7f_ffff, 4'b0000};
		// Round to nearest even
		rows[4]  = '{"tie_odd_rounds_up", 32'h3fc0_0000, 32'h3f80_0001, 32'h3fc0_0002, 4'b0001};
		rows[5]  = '{"tie_even_stays",    32'h3fc0_0000, 32'h3f80_0003, 32'h3fc0_0004, 4'b0001};
		rows[6]  = '{"sticky_only_down",  32'h3f80_0001, 32'h3f80_0001, 32'h3f80_0002, 4'b0001};
		rows[7]  = '{"guard_sticky_up",   32'h3fc0_0001, 32'h3fc0_0001, 32'h4010_0002, 4'b0001};
		rows[8]  = '{"max_sig_squared",   32'h3fff_ffff, 32'h3fff_ffff, 32'h407f_fffe, 4'b0001};
		rows[9]  = '{"round_carry_renorm", 32'h3ff8_0000, 32'h3f84_2108, 32'h4000_0000, 4'b0001};
		// Specials
		rows[10] = '{"inf_x_zero",        32'h7f80_0000, 32'h0000_0000, QNAN,          4'b1000};
		rows[11] = '{"zero_x_ninf",       32'h0000_0000, 32'hff80_0000, QNAN,          4'b1000};
		rows[12] = '{"qnan_x_one",        32'h7fc0_0000, 32'h3f80_0000, QNAN,          4'b0000};
		rows[13] = '{"snan_x_two",        32'h7f80_0001, 32'h4000_0000, QNAN,          4'b1000};
		rows[14] = '{"neg_qnan_x_zero",   32'hffc1_2345, 32'h0000_0000, QNAN,          4'b0000};
		rows[15] = '{"inf_x_neg2",        32'h7f80_0000, 32'hc000_0000, 32'hff80_0000, 4'b0000};
		rows[16] = '{"ninf_x_ninf",       32'hff80_0000, 32'hff80_0000, 32'h7f80_0000, 4'b0000};
		rows[17] = '{"nzero_x_five",      32'h8000_0000, 32'h40a0_0000, 32'h8000_0000, 4'b0000};
		rows[18] = '{"subnorm_x_neg2",    32'h0040_0000, 32'hc000_0000, 32'h8000_0000, 4'b0000};
		// Range limits
		rows[19] = '{"huge_x_huge",       32'h7f00_0000, 32'h7f00_0000, 32'h7f80_0000, 4'b0101};
		rows[20] = '{"nhuge_x_huge",      32'hff00_0000, 32'h7f00_0000, 32'hff80_0000, 4'b0101};
		rows[21] = '{"tiny_x_tiny",       32'h0080_0000, 32'h0080_0000, 32'h0000_0000, 4'b0011};
		rows[22] = '{"ntiny_x_tiny",      32'h8080_0000, 32'h0080_0000, 32'h8000_0000, 4'b0011};
	endtask

	initial begin : clock_gen
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin : watchdog
		repeat (N_ROWS * 200) @(posedge clk);
		$display("timed out waiting for results");
		$display("Test FAILED");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////////////////////////////////////////
	// Upstream issue and downstream consumer, one process on falling edges
	////////////////////////////////////////////////////////////////////////////

	initial begin : traffic
		int issued;
		int checked;
		int returned;        // Downstream credits handed back
		int up_credits;      // Free FIFO slots as seen upstream
		int credit_pulses;
		rst        = 1'b1;
		in_valid   = 1'b0;
		a_in.bits  = '0;
		b_in.bits  = '0;
		out_credit = 1'b0;
		issued        = 0;
		checked       = 0;
		returned      = 0;
		up_credits    = FIFO_SLOTS;
		credit_pulses = 0;
		load_table();
		repeat (5) @(negedge clk);
		rst = 1'b0;

		while (checked < N_ROWS) begin
			@(negedge clk);
			if (in_credit) begin
				up_credits++;
				credit_pulses++;
				assert (up_credits <= FIFO_SLOTS) else
					report_flow_error("in_credit returned a slot that was never spent");
			end
			if (out_valid) begin
				// Outstanding results before this one must leave a credit
				assert (checked - returned < OUT_SLOTS) else
					report_flow_error("out_valid rose with no downstream credit held");
				compare_word(rows[checked].name, "z", rows[checked].z, z);
				compare_word(rows[checked].name, "flags", 32'(rows[checked].flags),
					32'(flags));
				checked++;
			end
			// Consumer stalls at random
			if (checked > returned && lfsr_bit()) begin
				out_credit = 1'b1;
				returned++;
			end else begin
				out_credit = 1'b0;
			end
			// Back to back, with an idle cycle about one time in four
			if (issued < N_ROWS && up_credits > 0 && !(lfsr_bit() && lfsr_bit())) begin
				in_valid  = 1'b1;
				a_in.bits = rows[issued].a;
				b_in.bits = rows[issued].b;
				issued++;
				up_credits--;
			end else begin
				in_valid = 1'b0;
			end
		end

		// Nothing more may come out
		in_valid   = 1'b0;
		out_credit = 1'b0;
		repeat (10) begin
			@(negedge clk);
			assert (!out_valid) else
				report_flow_error("out_valid rose after every row was checked");
			if (in_credit)
				credit_pulses++;
		end
		assert (credit_pulses == N_ROWS) else
			report_flow_error("in_credit pulse count differs from the number of rows");
		$display("Test OK");
		$finish;
	end

endmodule

/* tb.f */
source/fpmul_pkg.sv
source/fpmul_decode.sv
source/fpmul_execute.sv
source/fpmul_result.sv
source/fpmul_credit_queue.sv
source/fpmul_top.sv
tb/fpmul_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fpmul_tb -f tb.f -o fpmul_sim

./obj_dir/fpmul_sim
